// File: logic/d_decode.sv
`timescale 1ns/1ps
`default_nettype none

module d_decode (
	input wire logic i_clk,
	input wire logic i_arst_n,
	input wire logic i_instr_valid,
	input wire mips_pkg::instr_u i_instr,
	output logic [mips_pkg::REG_W-1:0] o_rd_addr_a,
	output logic [mips_pkg::REG_W-1:0] o_rd_addr_b,
	input wire logic [mips_pkg::XLEN-1:0] i_rd_data_a,
	input wire logic [mips_pkg::XLEN-1:0] i_rd_data_b,
	output mips_pkg::de_t o_de
);

	import mips_pkg::*;

	instr_r_t ir;
	instr_i_t ii;
	logic [XLEN-1:0] imm_sext;
	logic [XLEN-1:0] imm_zext;
	de_t de_d;
	de_t de_q;
	logic valid_q;
	logic wr_en_q;

	assign ir = i_instr.r;
	assign ii = i_instr.i;

	// rs and rt sit at the same bits in both formats
	assign o_rd_addr_a = ir.rs;
	assign o_rd_addr_b = ir.rt;

	assign imm_sext = {{(XLEN-16){ii.imm16[15]}}, ii.imm16};
	assign imm_zext = {{(XLEN-16){1'b0}}, ii.imm16};

	always_comb begin
		de_d = '0;
		de_d.src_a = ir.rs;
		de_d.src_b = ir.rt;
		de_d.op_a = i_rd_data_a;
		de_d.op_b = i_rd_data_b;
		if (ir.opcode == OP_RTYPE) begin
			// r-type, result goes to rd
			de_d.rd = ir.rd;
			de_d.shamt = ir.shamt;
			de_d.wr_en = 1'b1;
			case (ir.funct)
				FN_SLL: de_d.alu_op = ALU_SLL;
				FN_SRL: de_d.alu_op = ALU_SRL;
				FN_SRA: de_d.alu_op = ALU_SRA;
				// no overflow trap, add same as addu
				FN_ADD, FN_ADDU: de_d.alu_op = ALU_ADD;
				FN_SUB, FN_SUBU: de_d.alu_op = ALU_SUB;
				FN_AND: de_d.alu_op = ALU_AND;
				FN_OR: de_d.alu_op = ALU_OR;
				FN_XOR: de_d.alu_op = ALU_XOR;
				FN_NOR: de_d.alu_op = ALU_NOR;
				FN_SLT: de_d.alu_op = ALU_SLT;
				FN_SLTU: de_d.alu_op = ALU_SLTU;
				// unknown funct, flows through without a write
				default: de_d.wr_en = 1'b0;
			endcase
		end else begin
			// i-type, result goes to rt, b is the immediate
			de_d.rd = ii.rt;
			de_d.use_imm = 1'b1;
			de_d.wr_en = 1'b1;
			case (ii.opcode)
				OP_ADDI, OP_ADDIU: begin
					de_d.alu_op = ALU_ADD;
					de_d.op_b = imm_sext;
				end
				// sltiu compares against the sign-extended value too
				OP_SLTI: begin
					de_d.alu_op = ALU_SLT;
					de_d.op_b = imm_sext;
				end
				OP_SLTIU: begin
					de_d.alu_op = ALU_SLTU;
					de_d.op_b = imm_sext;
				end
				OP_ANDI: begin
					de_d.alu_op = ALU_AND;
					de_d.op_b = imm_zext;
				end
				OP_ORI: begin
					de_d.alu_op = ALU_OR;
					de_d.op_b = imm_zext;
				end
				OP_XORI: begin
					de_d.alu_op = ALU_XOR;
					de_d.op_b = imm_zext;
				end
				// raw immediate, alu moves it to the upper half
				OP_LUI: begin
					de_d.alu_op = ALU_LUI;
					de_d.op_b = imm_zext;
				end
				default: begin
					de_d.wr_en = 1'b0;
					de_d.op_b = imm_zext;
				end
			endcase
		end
	end

	// control bits
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			valid_q <= 1'b0;
			wr_en_q <= 1'b0;
		end else begin
			valid_q <= i_instr_valid;
			wr_en_q <= i_instr_valid & de_d.wr_en;
		end
	end

	// payload, loaded only for a valid word
	always_ff @(posedge i_clk) begin
		if (i_instr_valid) begin
			de_q <= de_d;
		end
	end

	always_comb begin
		o_de = de_q;
		o_de.valid = valid_q;
		o_de.wr_en = wr_en_q;
	end

endmodule

`default_nettype wire

// File: logic/d_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module d_regfile (
	input wire logic i_clk,
	input wire logic i_arst_n,
	input wire logic [mips_pkg::REG_W-1:0] i_rd_addr_a,
	input wire logic [mips_pkg::REG_W-1:0] i_rd_addr_b,
	output logic [mips_pkg::XLEN-1:0] o_rd_data_a,
	output logic [mips_pkg::XLEN-1:0] o_rd_data_b,
	input wire logic i_wr_en,
	input wire logic [mips_pkg::REG_W-1:0] i_wr_addr,
	input wire logic [mips_pkg::XLEN-1:0] i_wr_data
);

	import mips_pkg::*;

	// r1..r31 only, r0 has no storage
	logic [XLEN-1:0] regs [1:NREGS-1];

	// one read port
	// r0 is zero, a same-cycle write to the address wins
	function automatic logic [XLEN-1:0] read_port(input logic [REG_W-1:0] addr);
		logic [XLEN-1:0] data;
		if (addr == '0) begin
			data = '0;
		end else if (i_wr_en && (i_wr_addr == addr)) begin
			data = i_wr_data;
		end else begin
			data = regs[addr];
		end
		return data;
	endfunction

	// writes to r0 dropped here
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int i = 1; i < NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wr_en && (i_wr_addr != '0)) begin
			regs[i_wr_addr] <= i_wr_data;
		end
	end

	// two identical combinational read ports
	always_comb begin
		o_rd_data_a = read_port(i_rd_addr_a);
		o_rd_data_b = read_port(i_rd_addr_b);
	end

endmodule

`default_nettype wire

// File: logic/e_alu.sv
`timescale 1ns/1ps
`default_nettype none

module e_alu (
	input wire logic [mips_pkg::XLEN-1:0] i_data_a,
	input wire logic [mips_pkg::XLEN-1:0] i_data_b,
	input wire mips_pkg::alu_op_e i_alu_ctrl,
	input wire logic [$clog2(mips_pkg::XLEN)-1:0] i_shamt,
	output logic [mips_pkg::XLEN-1:0] o_result
);

	import mips_pkg::*;

	always_comb begin
		// undefined control codes give zero
		o_result = '0;
		case (i_alu_ctrl)
			ALU_AND: o_result = i_data_a & i_data_b;
			ALU_OR: o_result = i_data_a | i_data_b;
			// add and addu
			ALU_ADD: o_result = i_data_a + i_data_b;
			// sub and subu
			ALU_SUB: o_result = i_data_a - i_data_b;
			ALU_NOR: o_result = ~(i_data_a | i_data_b);
			ALU_XOR: o_result = i_data_a ^ i_data_b;
			// shifts act on b, amount from the shamt field
			ALU_SLL: o_result = i_data_b << i_shamt;
			// zero fill
			ALU_SRL: o_result = i_data_b >> i_shamt;
			// sign fill
			ALU_SRA: o_result = $signed(i_data_b) >>> i_shamt;
			ALU_SLTU: begin
				o_result = {{(XLEN-1){1'b0}}, (i_data_a < i_data_b)};
			end
			ALU_SLT: begin
				o_result = {{(XLEN-1){1'b0}}, ($signed(i_data_a) < $signed(i_data_b))};
			end
			// low half of b into the upper half
			ALU_LUI: o_result = {i_data_b[XLEN/2-1:0], {(XLEN/2){1'b0}}};
			default: o_result = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: logic/e_execute.sv
`timescale 1ns/1ps
`default_nettype none

module e_execute (
	input wire logic i_clk,
	input wire logic i_arst_n,
	input wire mips_pkg::de_t i_de,
	input wire mips_pkg::ew_t i_fwd,
	output mips_pkg::ew_t o_ew
);

	import mips_pkg::*;

	logic fwd_live;
	logic fwd_hit_a;
	logic fwd_hit_b;
	logic [XLEN-1:0] alu_a;
	logic [XLEN-1:0] alu_b;
	logic [XLEN-1:0] alu_res;
	logic valid_q;
	logic wr_en_q;
	logic [REG_W-1:0] rd_q;
	logic [XLEN-1:0] result_q;

	// the instruction just ahead, if it writes a register
	assign fwd_live = i_fwd.valid & i_fwd.wr_en;

	// r0 never forwarded
	assign fwd_hit_a = fwd_live && (i_fwd.rd == i_de.src_a) && (i_de.src_a != '0);
	// immediate operand is never replaced
	assign fwd_hit_b = fwd_live && !i_de.use_imm
		&& (i_fwd.rd == i_de.src_b) && (i_de.src_b != '0);

	assign alu_a = fwd_hit_a ? i_fwd.result : i_de.op_a;
	assign alu_b = fwd_hit_b ? i_fwd.result : i_de.op_b;

	e_alu alu_i (
		.i_data_a(alu_a),
		.i_data_b(alu_b),
		.i_alu_ctrl(i_de.alu_op),
		.i_shamt(i_de.shamt),
		.o_result(alu_res)
	);

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			valid_q <= 1'b0;
			wr_en_q <= 1'b0;
		end else begin
			valid_q <= i_de.valid;
			wr_en_q <= i_de.valid & i_de.wr_en;
		end
	end

	// destination and result held until the next valid op
	always_ff @(posedge i_clk) begin
		if (i_de.valid) begin
			rd_q <= i_de.rd;
			result_q <= alu_res;
		end
	end

	assign o_ew = '{valid: valid_q, wr_en: wr_en_q, rd: rd_q, result: result_q};

endmodule

`default_nettype wire

// File: logic/exec_core.sv
`timescale 1ns/1ps
`default_nettype none

module exec_core (
	input wire logic i_clk,
	input wire logic i_arst_n,
	input wire logic i_instr_valid,
	input wire mips_pkg::instr_u i_instr,
	output logic o_wb_valid,
	output logic [mips_pkg::REG_W-1:0] o_wb_rd,
	output logic [mips_pkg::XLEN-1:0] o_wb_data
);

	import mips_pkg::*;

	logic [REG_W-1:0] rd_addr_a;
	logic [REG_W-1:0] rd_addr_b;
	logic [XLEN-1:0] rd_data_a;
	logic [XLEN-1:0] rd_data_b;
	de_t de;
	ew_t ew;
	logic wb_en;

	// a result is committed only when it actually writes
	assign wb_en = ew.valid & ew.wr_en;

	d_decode decode_i (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_instr_valid(i_instr_valid),
		.i_instr(i_instr),
		.o_rd_addr_a(rd_addr_a),
		.o_rd_addr_b(rd_addr_b),
		.i_rd_data_a(rd_data_a),
		.i_rd_data_b(rd_data_b),
		.o_de(de)
	);

	// written from the execute output, read by decode
	d_regfile regfile_i (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_rd_addr_a(rd_addr_a),
		.i_rd_addr_b(rd_addr_b),
		.o_rd_data_a(rd_data_a),
		.o_rd_data_b(rd_data_b),
		.i_wr_en(wb_en),
		.i_wr_addr(ew.rd),
		.i_wr_data(ew.result)
	);

	// ew loops back as the forwarding source
	e_execute execute_i (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_de(de),
		.i_fwd(ew),
		.o_ew(ew)
	);

	assign o_wb_valid = wb_en;
	assign o_wb_rd = ew.rd;
	assign o_wb_data = ew.result;

endmodule

`default_nettype wire

// File: logic/mips_pkg.sv
`default_nettype none

package mips_pkg;

	// datapath and register file geometry
	localparam int XLEN = 32;
	localparam int REG_W = 5;
	localparam int NREGS = 32;

	// major opcodes, only the ones this slice executes
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_ADDI = 6'h08,
		OP_ADDIU = 6'h09,
		OP_SLTI = 6'h0a,
		OP_SLTIU = 6'h0b,
		OP_ANDI = 6'h0c,
		OP_ORI = 6'h0d,
		OP_XORI = 6'h0e,
		OP_LUI = 6'h0f
	} opcode_e;

	// r-type function field
	typedef enum logic [5:0] {
		FN_SLL = 6'h00,
		FN_SRL = 6'h02,
		FN_SRA = 6'h03,
		FN_ADD = 6'h20,
		FN_ADDU = 6'h21,
		FN_SUB = 6'h22,
		FN_SUBU = 6'h23,
		FN_AND = 6'h24,
		FN_OR = 6'h25,
		FN_XOR = 6'h26,
		FN_NOR = 6'h27,
		FN_SLT = 6'h2a,
		FN_SLTU = 6'h2b
	} funct_e;

	// alu control, same numbering as the existing alu
	// 10, 11, 14, 15 left undefined
	typedef enum logic [3:0] {
		ALU_AND = 4'd0,
		ALU_OR = 4'd1,
		ALU_ADD = 4'd2,
		ALU_SLL = 4'd3,
		ALU_SRL = 4'd4,
		ALU_SRA = 4'd5,
		ALU_SUB = 4'd6,
		ALU_SLTU = 4'd7,
		ALU_LUI = 4'd8,
		ALU_SLT = 4'd9,
		ALU_NOR = 4'd12,
		ALU_XOR = 4'd13
	} alu_op_e;

	// r-type view of the instruction word
	typedef struct packed {
		opcode_e opcode;
		logic [REG_W-1:0] rs;
		logic [REG_W-1:0] rt;
		logic [REG_W-1:0] rd;
		logic [4:0] shamt;
		funct_e funct;
	} instr_r_t;

	// i-type view of the same word
	typedef struct packed {
		opcode_e opcode;
		logic [REG_W-1:0] rs;
		logic [REG_W-1:0] rt;
		logic [15:0] imm16;
	} instr_i_t;

	// one word, two decodings
	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_u;

	// decode to execute
	typedef struct packed {
		logic valid;
		logic wr_en;
		logic [REG_W-1:0] rd;
		logic [REG_W-1:0] src_a;
		logic [REG_W-1:0] src_b;
		// operand b already holds the extended immediate
		logic use_imm;
		alu_op_e alu_op;
		logic [4:0] shamt;
		logic [XLEN-1:0] op_a;
		logic [XLEN-1:0] op_b;
	} de_t;

	// execute to writeback
	typedef struct packed {
		logic valid;
		logic wr_en;
		logic [REG_W-1:0] rd;
		logic [XLEN-1:0] result;
	} ew_t;

endpackage

`default_nettype wire

// File: sim.f
logic/mips_pkg.sv
logic/d_regfile.sv
logic/d_decode.sv
logic/e_alu.sv
logic/e_execute.sv
logic/exec_core.sv
test/tb_exec_core.sv

// File: test/tb_exec_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exec_core;

	import mips_pkg::*;

	localparam int TIMEOUT_CYCLES = 4000;
	// launch edge to the edge where o_wb_valid rises
	localparam int LATENCY = 2;
	localparam logic [31:0] SEED = 32'had85_40ca;

	// one expected writeback
	typedef struct packed {
		logic [REG_W-1:0] rd;
		logic [XLEN-1:0] data;
		logic [31:0] at_edge;
	} wb_exp_t;

	logic clk;
	logic arst_n;
	logic instr_valid;
	instr_u instr;
	logic wb_valid;
	logic [REG_W-1:0] wb_rd;
	logic [XLEN-1:0] wb_data;

	// reference register file, r0 never written
	logic [XLEN-1:0] model [NREGS];
	wb_exp_t exp_q [$];
	logic [31:0] lfsr;
	int unsigned edge_cnt = 0;
	int unsigned err_cnt = 0;
	int unsigned check_cnt = 0;
	int unsigned test_cnt = 0;
	logic [5:0] arith_fn [8] = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR};

	exec_core dut_i (
		.i_clk(clk),
		.i_arst_n(arst_n),
		.i_instr_valid(instr_valid),
		.i_instr(instr),
		.o_wb_valid(wb_valid),
		.o_wb_rd(wb_rd),
		.o_wb_data(wb_data)
	);

	always #20 clk = ~clk;

	// edge count, also the run limit
	always @(posedge clk) begin
		edge_cnt <= edge_cnt + 1;
		if (edge_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Verification failed");
			$finish;
		end
	end

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		check_cnt++;
		if (got !== exp) begin
			$display("ERROR @%0t: %s mismatch, got %h expected %h", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	// outputs sampled mid-cycle, away from the rising edge
	always @(negedge clk) begin
		wb_exp_t e;
		if (!arst_n) begin
			check_eq(wb_valid, 1'b0, "o_wb_valid during reset");
		end else if (wb_valid) begin
			if (exp_q.size() == 0) begin
				$display("unexpected writeback at %0t: r%0d = %h with nothing pending",
					$time, wb_rd, wb_data);
				err_cnt++;
			end else begin
				e = exp_q.pop_front();
				check_eq(wb_rd, e.rd, "writeback register");
				check_eq(wb_data, e.data, "writeback data");
				check_eq(edge_cnt - e.at_edge, LATENCY, "writeback latency");
			end
		end
	end

	// galois form, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one step per bit taken
	function automatic logic [31:0] get_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [4:0] pick_reg();
		logic [4:0] r;
		r = get_bits(5);
		return (r == 0) ? 5'd1 : r;
	endfunction

	// expected r-type result, straight from the instruction definitions
	function automatic logic [31:0] model_r(input logic [5:0] fn, input logic [31:0] a,
		input logic [31:0] b, input logic [4:0] sh);
		logic [31:0] fill;
		fill = b[31] ? ~(32'hffff_ffff >> sh) : 32'h0;
		case (fn)
			FN_ADD, FN_ADDU: return a + b;
			FN_SUB, FN_SUBU: return a - b;
			FN_AND: return a & b;
			FN_OR: return a | b;
			FN_XOR: return a ^ b;
			FN_NOR: return ~(a | b);
			FN_SLL: return b << sh;
			FN_SRL: return b >> sh;
			FN_SRA: return (b >> sh) | fill;
			// differing signs decide on a alone
			FN_SLT: return (a[31] != b[31]) ? {31'h0, a[31]} : {31'h0, a < b};
			FN_SLTU: return {31'h0, a < b};
			default: return 32'h0;
		endcase
	endfunction

	function automatic logic [31:0] model_i(input logic [5:0] op, input logic [31:0] a,
		input logic [15:0] imm);
		logic [31:0] sx;
		logic [31:0] zx;
		sx = {{16{imm[15]}}, imm};
		zx = {16'h0, imm};
		case (op)
			OP_ADDI, OP_ADDIU: return a + sx;
			OP_SLTI: return (a[31] != sx[31]) ? {31'h0, a[31]} : {31'h0, a < sx};
			OP_SLTIU: return {31'h0, a < sx};
			OP_ANDI: return a & zx;
			OP_ORI: return a | zx;
			OP_XORI: return a ^ zx;
			OP_LUI: return {imm, 16'h0};
			default: return 32'h0;
		endcase
	endfunction

	// launch one word, queue its writeback if it has one
	task automatic post(input logic [31:0] word, input logic writes, input logic [4:0] rd,
		input logic [31:0] res);
		wb_exp_t e;
		@(posedge clk);
		instr_valid <= 1'b1;
		instr <= word;
		if (writes) begin
			e.rd = rd;
			e.data = res;
			// edge_cnt still holds the count before this edge
			e.at_edge = edge_cnt + 1;
			exp_q.push_back(e);
			if (rd != 0) begin
				model[rd] = res;
			end
		end
	endtask

	task automatic issue_r(input logic [5:0] fn, input logic [4:0] rd, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] sh);
		post({6'h00, rs, rt, rd, sh, fn}, 1'b1, rd, model_r(fn, model[rs], model[rt], sh));
	endtask

	task automatic issue_i(input logic [5:0] op, input logic [4:0] rt, input logic [4:0] rs,
		input logic [15:0] imm);
		post({op, rs, rt, imm}, 1'b1, rt, model_i(op, model[rs], imm));
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			instr_valid <= 1'b0;
		end
	endtask

	// lui then ori, the ori reads its own target one op later
	task automatic load_reg(input logic [4:0] r, input logic [31:0] v);
		issue_i(OP_LUI, r, 5'd0, v[31:16]);
		issue_i(OP_ORI, r, r, v[15:0]);
	endtask

	task automatic finish_test(input string name, input int unsigned err0);
		idle(4);
		if (exp_q.size() != 0) begin
			$display("missing writeback: %0d results never appeared in %s", exp_q.size(), name);
			err_cnt += exp_q.size();
			exp_q.delete();
		end
		test_cnt++;
		$display("test %s: %s, %0d errors", name, (err_cnt == err0) ? "ok" : "FAILED",
			err_cnt - err0);
	endtask

	task automatic test_reset();
		int unsigned err0;
		err0 = err_cnt;
		// the monitor flags any writeback here
		idle(10);
		issue_r(FN_ADD, 5'd5, 5'd0, 5'd0, 5'd0);
		issue_r(FN_ADD, 5'd6, 5'd7, 5'd9, 5'd0);
		finish_test("reset", err0);
	endtask

	task automatic test_arith();
		int unsigned err0;
		logic [4:0] ra;
		logic [4:0] rb;
		err0 = err_cnt;
		for (int i = 0; i < 40; i++) begin
			ra = pick_reg();
			rb = pick_reg();
			if (rb == ra) begin
				rb = (ra % 31) + 1;
			end
			load_reg(ra, get_bits(32));
			load_reg(rb, get_bits(32));
			// rd may land on ra or rb, the model follows
			for (int k = 0; k < 8; k++) begin
				issue_r(arith_fn[k], pick_reg(), ra, rb, 5'd0);
			end
		end
		finish_test("arith", err0);
	endtask

	task automatic test_shift_cmp();
		int unsigned err0;
		logic [31:0] v;
		logic [4:0] sh;
		err0 = err_cnt;
		for (int i = 0; i < 6; i++) begin
			v = get_bits(32);
			// odd rounds negative for sra
			if (i % 2) begin
				v[31] = 1'b1;
			end
			load_reg(5'd3, v);
			sh = get_bits(5);
			issue_r(FN_SLL, 5'd4, 5'd0, 5'd3, sh);
			issue_r(FN_SRL, 5'd5, 5'd0, 5'd3, sh);
			issue_r(FN_SRA, 5'd6, 5'd0, 5'd3, sh);
		end
		// sign bits differ so slt and sltu disagree
		for (int i = 0; i < 4; i++) begin
			load_reg(5'd7, get_bits(32) | 32'h8000_0000);
			load_reg(5'd8, get_bits(32) & 32'h7fff_ffff);
			issue_r(FN_SLT, 5'd9, 5'd7, 5'd8, 5'd0);
			issue_r(FN_SLTU, 5'd10, 5'd7, 5'd8, 5'd0);
			issue_r(FN_SLT, 5'd11, 5'd8, 5'd7, 5'd0);
			issue_r(FN_SLTU, 5'd12, 5'd8, 5'd7, 5'd0);
		end
		finish_test("shift_cmp", err0);
	endtask

	task automatic test_imm();
		int unsigned err0;
		logic [15:0] imm;
		err0 = err_cnt;
		for (int i = 0; i < 4; i++) begin
			load_reg(5'd13, get_bits(32));
			// bit 15 set, sign and zero extension differ
			imm = get_bits(16) | 16'h8000;
			issue_i(OP_ADDI, 5'd14, 5'd13, imm);
			issue_i(OP_ADDIU, 5'd15, 5'd13, imm);
			issue_i(OP_SLTI, 5'd16, 5'd13, imm);
			issue_i(OP_SLTIU, 5'd17, 5'd13, imm);
			issue_i(OP_ANDI, 5'd18, 5'd13, imm);
			issue_i(OP_ORI, 5'd19, 5'd13, imm);
			issue_i(OP_XORI, 5'd20, 5'd13, imm);
			issue_i(OP_LUI, 5'd21, 5'd0, imm);
		end
		finish_test("imm", err0);
	endtask

	task automatic test_hazard();
		int unsigned err0;
		logic [4:0] rd;
		logic [4:0] rs;
		logic [4:0] rt;
		err0 = err_cnt;
		for (int r = 1; r <= 3; r++) begin
			load_reg(r[4:0], get_bits(32));
		end
		// three registers only, so distance 1 and 2 deps are constant
		for (int i = 0; i < 30; i++) begin
			rd = 1 + (get_bits(2) % 3);
			rs = 1 + (get_bits(2) % 3);
			rt = 1 + (get_bits(2) % 3);
			// immediate op, rt is the target and must not be forwarded into b
			if (i % 4 == 3) begin
				issue_i(OP_ADDIU, rd, rs, get_bits(16));
			end else begin
				issue_r(arith_fn[get_bits(3)], rd, rs, rt, 5'd0);
			end
		end
		// read back the final values
		for (int r = 1; r <= 3; r++) begin
			issue_r(FN_OR, 5'(21 + r), r[4:0], 5'd0, 5'd0);
		end
		finish_test("hazard", err0);
	endtask

	task automatic test_special();
		int unsigned err0;
		err0 = err_cnt;
		load_reg(5'd1, get_bits(32));
		// r0 target still reports a writeback
		issue_i(OP_ADDIU, 5'd0, 5'd1, 16'h0005);
		issue_r(FN_ADDU, 5'd4, 5'd0, 5'd0, 5'd0);
		issue_r(FN_OR, 5'd5, 5'd0, 5'd1, 5'd0);
		idle(2);
		issue_r(FN_XOR, 5'd6, 5'd0, 5'd0, 5'd0);
		// unsupported opcode and funct between valid ops
		issue_r(FN_ADDU, 5'd7, 5'd1, 5'd1, 5'd0);
		post({6'h3f, 5'd1, 5'd7, 16'hffff}, 1'b0, 5'd0, 32'h0);
		issue_r(FN_SUBU, 5'd8, 5'd7, 5'd1, 5'd0);
		post({6'h00, 5'd8, 5'd1, 5'd8, 5'd0, 6'h3f}, 1'b0, 5'd0, 32'h0);
		issue_r(FN_OR, 5'd9, 5'd8, 5'd0, 5'd0);
		// r7 and r8 untouched by the dropped words
		issue_r(FN_OR, 5'd10, 5'd7, 5'd8, 5'd0);
		finish_test("special", err0);
	endtask

	initial begin
		clk = 1'b0;
		arst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		lfsr = SEED;
		for (int r = 0; r < NREGS; r++) begin
			model[r] = '0;
		end
		repeat (8) @(posedge clk);
		arst_n <= 1'b1;
		test_reset();
		test_arith();
		test_shift_cmp();
		test_imm();
		test_hazard();
		test_special();
		$display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
